// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/cart_loader.sv ====
// Cartridge download path with memory write credits and host wait
`timescale 1ns/1ps
`default_nettype none

`include "n64_load_defines.svh"

module cart_loader
	import n64_load_pkg::*;
(
	input  logic         clk_1x,
	input  logic         rst_n,
	input  logic         ioctl_download,
	input  ioctl_index_t ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  half_t        ioctl_dout,
	input  logic         ioctl_wr,
	input  logic         sdram_credit,
	output logic         active,
	output logic         ioctl_wait,
	output logic         writes_pending,
	output cart_addr_t   sdram_addr,
	output word_t        sdram_data,
	output logic         sdram_wr
);

	localparam credit_t CREDIT_MAX = credit_t'(`SDRAM_CREDITS);
	localparam cart_addr_t CART_BASE = cart_addr_t'(`CART_START);

	cart_addr_t mem_addr;
	credit_t credits;

	// ====================
	// Download and packing
	// ====================

	assign mem_addr = cart_addr_t'(ioctl_addr) + CART_BASE;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else begin
			active <= ioctl_download && (ioctl_index[5:0] == 6'(`CART_INDEX));
		end
	end

	word_packer #(
		.addr_t   (cart_addr_t),
		.BYTE_SWAP(1'b0)
	) u_packer (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.wr         (ioctl_wr && active),
		.addr_in    (mem_addr),
		.second_half(ioctl_addr[1]),
		.din        (ioctl_dout),
		.valid      (sdram_wr),
		.addr       (sdram_addr),
		.data       (sdram_data)
	);

	// ====================
	// Credit counter
	// ====================

	// A write spends one, a returned credit gives one back
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({sdram_wr, sdram_credit})
				2'b10: credits <= credits - credit_t'(1);
				2'b01: credits <= credits + credit_t'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Host stalls once the last credit is spent
	// and resumes the cycle after one comes back
	assign ioctl_wait = active && (credits == '0);

	// Memory still owes completions
	assign writes_pending = credits < CREDIT_MAX;

	// Host honours the wait line, so no write goes out uncovered
	a_write_has_credit: assert property (
		@(posedge clk_1x) disable iff (!rst_n)
		sdram_wr |-> (credits != '0)
	);

	// Memory returns only what it was given
	a_no_extra_credit: assert property (
		@(posedge clk_1x) disable iff (!rst_n)
		sdram_credit |-> (credits != CREDIT_MAX)
	);

endmodule

`default_nettype wire

// ==== hdl/load_status.sv ====
// Core reset hold, sticky cartridge loaded flag and busy LED
`timescale 1ns/1ps
`default_nettype none

module load_status (
	input  logic clk_1x,
	input  logic rst_n,
	input  logic pif_active,
	input  logic cart_active,
	input  logic writes_pending,
	output logic core_reset,
	output logic cart_loaded,
	output logic led_user
);

	// ====================
	// Core control
	// ====================

	// Core held in reset while any image streams in
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			core_reset <= 1'b0;
		end else begin
			core_reset <= pif_active || cart_active;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			cart_loaded <= 1'b0;
		end else if (cart_active) begin
			cart_loaded <= 1'b1;
		end
	end

	// ====================
	// User LED
	// ====================

	// Lit until the memory has taken every word
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			led_user <= 1'b0;
		end else begin
			led_user <= cart_active || writes_pending;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/n64_load_defines.svh ====
// Widths, download indices, cartridge base and credit count of the ROM loader
`ifndef N64_LOAD_DEFINES_SVH
`define N64_LOAD_DEFINES_SVH

// Host and packed data widths
`define HALF_W 16
`define WORD_W 32

// Host byte address and boot ROM word address
`define IOCTL_ADDR_W 27
`define PIF_ADDR_W 10

// Low six bits of the download index
`define PIF_INDEX 0
`define CART_INDEX 1

// Cartridge image sits 8 MB into memory
`define CART_START 8388608

// Write credits held by the loader after reset
`define SDRAM_CREDITS 2
`define CREDIT_W 2

`endif

// ==== hdl/n64_load_pkg.sv ====
// Data, address and credit types shared by the ROM loader blocks
`default_nettype none

`include "n64_load_defines.svh"

package n64_load_pkg;

	// Host side
	typedef logic [`HALF_W-1:0] half_t;
	typedef logic [`IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [7:0] ioctl_index_t;

	// Packed words towards both targets
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`PIF_ADDR_W-1:0] pif_addr_t;
	typedef logic [`IOCTL_ADDR_W-1:0] cart_addr_t;

	// Memory write credits
	typedef logic [`CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

// ==== hdl/n64_loader_top.sv ====
// Top level joining boot ROM path, cartridge path and load status
`timescale 1ns/1ps
`default_nettype none

module n64_loader_top
	import n64_load_pkg::*;
(
	input  logic         clk_1x,
	input  logic         rst_n,

	// Host download
	input  logic         ioctl_download,
	input  ioctl_index_t ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  half_t        ioctl_dout,
	input  logic         ioctl_wr,
	output logic         ioctl_wait,

	// Boot ROM write port
	output pif_addr_t    pifrom_wraddress,
	output word_t        pifrom_wrdata,
	output logic         pifrom_wren,

	// Memory write port
	output cart_addr_t   sdram_addr,
	output word_t        sdram_data,
	output logic         sdram_wr,
	input  logic         sdram_credit,

	// Status
	output logic         core_reset,
	output logic         cart_loaded,
	output logic         led_user
);

	logic pif_active;
	logic cart_active;
	logic writes_pending;

	pif_rom_loader u_pif (
		.clk_1x          (clk_1x),
		.rst_n           (rst_n),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_addr      (ioctl_addr),
		.ioctl_dout      (ioctl_dout),
		.ioctl_wr        (ioctl_wr),
		.active          (pif_active),
		.pifrom_wraddress(pifrom_wraddress),
		.pifrom_wrdata   (pifrom_wrdata),
		.pifrom_wren     (pifrom_wren)
	);

	cart_loader u_cart (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.sdram_credit  (sdram_credit),
		.active        (cart_active),
		.ioctl_wait    (ioctl_wait),
		.writes_pending(writes_pending),
		.sdram_addr    (sdram_addr),
		.sdram_data    (sdram_data),
		.sdram_wr      (sdram_wr)
	);

	load_status u_status (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.pif_active    (pif_active),
		.cart_active   (cart_active),
		.writes_pending(writes_pending),
		.core_reset    (core_reset),
		.cart_loaded   (cart_loaded),
		.led_user      (led_user)
	);

endmodule

`default_nettype wire

// ==== hdl/pif_rom_loader.sv ====
// Boot ROM download path driving the ROM write port
`timescale 1ns/1ps
`default_nettype none

`include "n64_load_defines.svh"

module pif_rom_loader
	import n64_load_pkg::*;
(
	input  logic         clk_1x,
	input  logic         rst_n,
	input  logic         ioctl_download,
	input  ioctl_index_t ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  half_t        ioctl_dout,
	input  logic         ioctl_wr,
	output logic         active,
	output pif_addr_t    pifrom_wraddress,
	output word_t        pifrom_wrdata,
	output logic         pifrom_wren
);

	pif_addr_t word_addr;

	// Index bit 6 picks the upper half of the ROM
	assign word_addr = {ioctl_index[6], ioctl_addr[10:2]};

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else begin
			active <= ioctl_download && (ioctl_index[5:0] == 6'(`PIF_INDEX));
		end
	end

	word_packer #(
		.addr_t   (pif_addr_t),
		.BYTE_SWAP(1'b1)
	) u_packer (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.wr         (ioctl_wr && active),
		.addr_in    (word_addr),
		.second_half(ioctl_addr[1]),
		.din        (ioctl_dout),
		.valid      (pifrom_wren),
		.addr       (pifrom_wraddress),
		.data       (pifrom_wrdata)
	);

	// ROM writes belong to a running boot ROM download
	a_wren_in_download: assert property (
		@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren |-> active
	);

endmodule

`default_nettype wire

// ==== hdl/word_packer.sv ====
// Halfword to word packer with optional byte swap, generic over the address payload
`timescale 1ns/1ps
`default_nettype none

module word_packer
	import n64_load_pkg::*;
#(
	parameter type addr_t = logic,
	parameter bit BYTE_SWAP = 1'b0
) (
	input  logic  clk_1x,
	input  logic  rst_n,
	input  logic  wr,
	input  addr_t addr_in,
	input  logic  second_half,
	input  half_t din,
	output logic  valid,
	output addr_t addr,
	output word_t data
);

	half_t first_q;
	addr_t first_addr_q;
	word_t packed_word;

	function automatic half_t swap_bytes(input half_t h);
		return {h[7:0], h[15:8]};
	endfunction

	// ====================
	// Word assembly
	// ====================

	// Boot ROM order puts the first half on top
	always_comb begin
		if (BYTE_SWAP) begin
			packed_word = {swap_bytes(first_q), swap_bytes(din)};
		end else begin
			packed_word = {din, first_q};
		end
	end

	// First half and its address wait here
	always_ff @(posedge clk_1x) begin
		if (wr && !second_half) begin
			first_q <= din;
			first_addr_q <= addr_in;
		end
	end

	// Output word, held until the next pair completes
	always_ff @(posedge clk_1x) begin
		if (wr && second_half) begin
			data <= packed_word;
			addr <= first_addr_q;
		end
	end

	// One-cycle strobe per completed word
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else begin
			valid <= wr && second_half;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/n64_load_pkg.sv
hdl/word_packer.sv
hdl/pif_rom_loader.sv
hdl/cart_loader.sv
hdl/load_status.sv
hdl/n64_loader_top.sv
tb/tb_clock.sv
tb/tb_top.sv

// ==== tb/tb_clock.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 5,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_1x,
	output logic rst_n
);

	initial begin
		clk_1x = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) clk_1x = ~clk_1x;
		end
	end

	// Released just after a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_1x);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
// Testbench for the ROM loader top level with a credit returning memory model
`timescale 1ns/1ps
`default_nettype none

`include "n64_load_defines.svh"

module tb_top
	import n64_load_pkg::*;
();

	localparam int WAIT_LIMIT = 300;
	localparam int PIF_WORDS = 16;
	localparam int CART_WORDS = 24;
	localparam int STALL_WORDS = 8;
	localparam int CREDITS = `SDRAM_CREDITS;
	localparam ioctl_addr_t CART_OFFSET = ioctl_addr_t'(`CART_START);

	logic clk_1x, rst_n;
	logic ioctl_download, ioctl_wr, ioctl_wait, sdram_credit;
	ioctl_index_t ioctl_index;
	ioctl_addr_t ioctl_addr;
	half_t ioctl_dout;
	pif_addr_t pifrom_wraddress;
	word_t pifrom_wrdata, sdram_data;
	cart_addr_t sdram_addr;
	logic pifrom_wren, sdram_wr, core_reset, cart_loaded, led_user;

	// Expected state built from the host traffic
	logic pif_live, cart_live, loaded_ref, pif_second, cart_second, credit_pause;
	int outstanding, rom_words, mem_words, sent_rom, sent_mem;
	ioctl_addr_t first_addr;
	half_t first_data;
	pif_addr_t exp_pif_addr;
	cart_addr_t exp_cart_addr;
	word_t exp_pif_data, exp_cart_data;
	int error_count = 0;
	int timeout_count = 0;

	tb_clock clock_gen (.clk_1x(clk_1x), .rst_n(rst_n));

	n64_loader_top uut (
		.clk_1x(clk_1x), .rst_n(rst_n),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_wr(ioctl_wr), .ioctl_wait(ioctl_wait),
		.pifrom_wraddress(pifrom_wraddress), .pifrom_wrdata(pifrom_wrdata),
		.pifrom_wren(pifrom_wren),
		.sdram_addr(sdram_addr), .sdram_data(sdram_data),
		.sdram_wr(sdram_wr), .sdram_credit(sdram_credit),
		.core_reset(core_reset), .cart_loaded(cart_loaded), .led_user(led_user)
	);

	assign pif_second = ioctl_wr && ioctl_addr[1] && pif_live;
	assign cart_second = ioctl_wr && ioctl_addr[1] && cart_live;

	// ====================
	// Reference model
	// ====================

	always @(posedge clk_1x) begin
		if (!rst_n) begin
			pif_live <= 1'b0;
			cart_live <= 1'b0;
			loaded_ref <= 1'b0;
			outstanding <= 0;
			rom_words <= 0;
			mem_words <= 0;
		end else begin
			pif_live <= ioctl_download && (ioctl_index[5:0] == 6'(`PIF_INDEX));
			cart_live <= ioctl_download && (ioctl_index[5:0] == 6'(`CART_INDEX));
			if (cart_live) begin
				loaded_ref <= 1'b1;
			end
			outstanding <= outstanding + int'(sdram_wr) - int'(sdram_credit);
			rom_words <= rom_words + int'(pifrom_wren);
			mem_words <= mem_words + int'(sdram_wr);
			if (ioctl_wr && !ioctl_addr[1]) begin
				first_addr <= ioctl_addr;
				first_data <= ioctl_dout;
			end
			// Boot ROM swaps bytes and puts the first half on top
			if (ioctl_wr && ioctl_addr[1]) begin
				exp_pif_addr <= {ioctl_index[6], first_addr[10:2]};
				exp_pif_data <= {first_data[7:0], first_data[15:8],
					ioctl_dout[7:0], ioctl_dout[15:8]};
				exp_cart_addr <= first_addr + CART_OFFSET;
				exp_cart_data <= {ioctl_dout, first_data};
			end
		end
	end

	// Memory returns each credit 1 to 4 cycles after its write
	initial begin : memory_model
		int due_q[$];
		int cycle_cnt;
		cycle_cnt = 0;
		sdram_credit = 1'b0;
		forever begin
			@(posedge clk_1x);
			#1;
			cycle_cnt++;
			if (!rst_n) begin
				due_q.delete();
				sdram_credit = 1'b0;
			end else begin
				if (sdram_wr) begin
					due_q.push_back(cycle_cnt + int'($urandom_range(4, 1)));
				end
				if (!credit_pause && due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
					sdram_credit = 1'b1;
					void'(due_q.pop_front());
				end else begin
					sdram_credit = 1'b0;
				end
			end
		end
	end

	// ====================
	// Checks
	// ====================

	a_reset_quiet: assert property (@(posedge clk_1x) !rst_n |=>
		!(pifrom_wren || sdram_wr || ioctl_wait || core_reset || cart_loaded || led_user))
		else report_mismatch("output high after reset");
	a_rom_word: assert property (@(posedge clk_1x) disable iff (!rst_n) pif_second |=>
		(pifrom_wren && pifrom_wraddress == exp_pif_addr && pifrom_wrdata == exp_pif_data))
		else report_mismatch("boot ROM write missing or wrong");
	a_rom_no_extra: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren |-> $past(pif_second)) else report_mismatch("unexpected boot ROM write");
	a_mem_word: assert property (@(posedge clk_1x) disable iff (!rst_n) cart_second |=>
		(sdram_wr && sdram_addr == exp_cart_addr && sdram_data == exp_cart_data))
		else report_mismatch("memory write missing or wrong");
	a_mem_no_extra: assert property (@(posedge clk_1x) disable iff (!rst_n)
		sdram_wr |-> $past(cart_second)) else report_mismatch("unexpected memory write");
	a_wait_level: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait == (cart_live && outstanding == CREDITS))
		else report_mismatch("ioctl_wait wrong");
	a_write_with_credit: assert property (@(posedge clk_1x) disable iff (!rst_n)
		sdram_wr |-> (outstanding < CREDITS))
		else report_mismatch("memory write without credit");
	a_core_reset: assert property (@(posedge clk_1x) disable iff (!rst_n)
		core_reset == $past(pif_live || cart_live)) else report_mismatch("core_reset wrong");
	a_loaded: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cart_loaded == loaded_ref) else report_mismatch("cart_loaded wrong");
	a_led: assert property (@(posedge clk_1x) disable iff (!rst_n)
		led_user == $past(cart_live || outstanding != 0)) else report_mismatch("led_user wrong");

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("MISMATCH %0t: %s", $time, msg);
	endtask

	task automatic note_timeout(input string what);
		timeout_count++;
		$display("Timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge clk_1x);
		#1;
	endtask

	// One host halfword, held back while the loader asks to wait
	task automatic send_half(input ioctl_addr_t addr, input half_t data);
		int cycles;
		cycles = 0;
		while (ioctl_wait && timeout_count == 0) begin
			next_cycle();
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				note_timeout("ioctl_wait to fall");
			end
		end
		if (timeout_count == 0) begin
			ioctl_addr = addr;
			ioctl_dout = data;
			ioctl_wr = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0;
		end
	endtask

	task automatic load_image(input ioctl_index_t index, input int base_word, input int words);
		ioctl_addr_t addr;
		ioctl_index = index;
		ioctl_download = 1'b1;
		repeat (2) next_cycle();
		for (int i = 0; i < words; i++) begin
			addr = ioctl_addr_t'((base_word + i) * 4);
			send_half(addr, half_t'($urandom));
			send_half(addr | ioctl_addr_t'(2), half_t'($urandom));
		end
		ioctl_download = 1'b0;
		repeat (2) next_cycle();
	endtask

	// Loop until the memory has returned every credit and the LED is off
	task automatic drain_credits();
		int cycles;
		cycles = 0;
		while ((outstanding != 0 || led_user) && timeout_count == 0) begin
			next_cycle();
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				note_timeout("credits to return");
			end
		end
	endtask

	// Starve the memory until the host stalls, then let credits flow again
	task automatic stall_then_release();
		int cycles;
		cycles = 0;
		credit_pause = 1'b1;
		while (!ioctl_wait && timeout_count == 0) begin
			next_cycle();
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				note_timeout("ioctl_wait to rise");
			end
		end
		repeat (6) next_cycle();
		credit_pause = 1'b0;
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin : stimulus
		int cycles;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		credit_pause = 1'b0;
		sent_rom = 0;
		sent_mem = 0;
		cycles = 0;
		void'($urandom(32'hc212));
		next_cycle();
		while (!rst_n && timeout_count == 0) begin
			next_cycle();
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				note_timeout("reset release");
			end
		end
		repeat (4) next_cycle();

		// Boot ROM, index bit 6 picks the ROM half
		for (int n = 0; n < 2; n++) begin
			load_image({1'b0, 1'($urandom), 6'(`PIF_INDEX)},
				int'($urandom_range(511 - PIF_WORDS, 0)), PIF_WORDS);
			sent_rom += PIF_WORDS;
		end

		load_image(8'(`CART_INDEX), int'($urandom_range(1 << 20, 0)), CART_WORDS);
		sent_mem += CART_WORDS;
		drain_credits();

		// Back-pressure run
		fork
			load_image(8'(`CART_INDEX), int'($urandom_range(1 << 20, 0)), STALL_WORDS);
			stall_then_release();
		join
		sent_mem += STALL_WORDS;
		drain_credits();
		repeat (4) next_cycle();

		assert (rom_words == sent_rom) else report_mismatch("boot ROM word count differs");
		assert (mem_words == sent_mem) else report_mismatch("memory word count differs");
		$display("Errors: %0d, timeouts: %0d, boot ROM words: %0d, memory words: %0d",
			error_count, timeout_count, rom_words, mem_words);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
